/* design/bus_decoder.sv */
`default_nettype none

module bus_decoder (
    input  logic [31:0]                 data_addr,
    input  logic                        ren,
    input  logic                        wen,
    input  logic [31:0]                 wdata,
    input  logic [31:0]                 pc,
    output logic                        instr_sel,
    output logic [bus_pkg::INDEX_W-1:0] instr_index,
    slave_if.decoder                    slv [bus_pkg::SLAVE_COUNT],
    output logic [1:0]                  hit_slot,
    output logic                        hit
);

    bus_pkg::bus_addr_u daddr;
    bus_pkg::bus_addr_u iaddr;

    logic prog_hit;
    logic cnt_hit;
    logic [bus_pkg::SLAVE_COUNT-1:0] slot_sel;

    assign daddr.raw = data_addr;
    assign iaddr.raw = pc;

    // instruction fetch only from the program page
    assign instr_sel   = (iaddr.fields.page == bus_pkg::PROG_PAGE);
    assign instr_index = iaddr.fields.word;

    // data side region match
    always_comb begin
        prog_hit = (daddr.fields.page == bus_pkg::PROG_PAGE);
        cnt_hit  = (daddr.fields.page == bus_pkg::COUNTER_PAGE) &&
                   (daddr.fields.word < 10'(bus_pkg::TICK_COUNT));
        hit      = prog_hit || cnt_hit;

        if (cnt_hit) begin
            hit_slot = 2'(daddr.fields.word) + 2'd1;  // counters start at slot 1
        end else begin
            hit_slot = 2'd0;  // memory or don't care on a miss
        end
    end

    // route strobes to the one matching slot
    for (genvar k = 0; k < bus_pkg::SLAVE_COUNT; k++) begin : g_slot
        assign slot_sel[k]  = hit && (hit_slot == 2'(k));
        assign slv[k].sel   = slot_sel[k];
        assign slv[k].ren   = slot_sel[k] && ren;
        assign slv[k].wen   = slot_sel[k] && wen;
        assign slv[k].index = daddr.fields.word;
        assign slv[k].wdata = wdata;
    end

endmodule

`default_nettype wire

/* design/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    // address split into page, word and byte
    localparam int PAGE_W  = 20;
    localparam int INDEX_W = 10;
    localparam int BYTE_W  = 2;

    // memory map compared against the page field
    localparam logic [PAGE_W-1:0] PROG_PAGE    = 20'd1;
    localparam logic [PAGE_W-1:0] COUNTER_PAGE = 20'd2;

    localparam int PROG_WORDS = 1024;  // full word field of the program page

    // tick counter bank
    localparam int TICK_COUNT = 2;
    localparam int TICK_PRESCALE [TICK_COUNT] = '{1, 27};  // clocks per count step

    // slot 0 is program memory and counters follow
    localparam int SLAVE_COUNT = TICK_COUNT + 1;

    typedef struct packed {
        logic [PAGE_W-1:0]  page;      // region select
        logic [INDEX_W-1:0] word;      // word index inside the region
        logic [BYTE_W-1:0]  byte_sel;  // byte lane ignored by word slaves
    } bus_addr_t;

    typedef union packed {
        logic [31:0] raw;
        bus_addr_t   fields;
    } bus_addr_u;

endpackage

`default_nettype wire

/* design/bus_top.sv */
`default_nettype none

module bus_top (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] pc,
    output logic [31:0] instr,
    input  logic [31:0] data_addr,
    input  logic        ren,
    input  logic        wen,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        rvalid
);

    slave_if slv [bus_pkg::SLAVE_COUNT] ();  // slot 0 memory, then counters

    logic                        instr_sel;
    logic [bus_pkg::INDEX_W-1:0] instr_index;
    logic [1:0]                  hit_slot;
    logic                        hit;

    bus_decoder bus_decoder_i (
        .data_addr   (data_addr),
        .ren         (ren),
        .wen         (wen),
        .wdata       (wdata),
        .pc          (pc),
        .instr_sel   (instr_sel),
        .instr_index (instr_index),
        .slv         (slv),
        .hit_slot    (hit_slot),
        .hit         (hit)
    );

    program_mem program_mem_i (
        .clk         (clk),
        .reset       (reset),
        .instr_sel   (instr_sel),
        .instr_index (instr_index),
        .instr       (instr),
        .port        (slv[0])
    );

    for (genvar k = 0; k < bus_pkg::TICK_COUNT; k++) begin : g_tick
        tick_counter #(
            .PRESCALE (bus_pkg::TICK_PRESCALE[k])
        ) tick_counter_i (
            .clk   (clk),
            .reset (reset),
            .port  (slv[k+1])
        );
    end

    read_mux read_mux_i (
        .clk      (clk),
        .reset    (reset),
        .ren      (ren),
        .hit      (hit),
        .hit_slot (hit_slot),
        .slv      (slv),
        .rdata    (rdata),
        .rvalid   (rvalid)
    );

endmodule

`default_nettype wire

/* design/program_mem.sv */
`default_nettype none

module program_mem (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        instr_sel,
    input  logic [bus_pkg::INDEX_W-1:0] instr_index,
    output logic [31:0]                 instr,
    slave_if.slave                      port
);

    logic [31:0] mem [bus_pkg::PROG_WORDS];

    // read-only instruction port
    always_ff @(posedge clk) begin
        if (reset) begin
            instr <= '0;
        end else if (instr_sel) begin
            instr <= mem[instr_index];
        end else begin
            instr <= '0;  // pc off the program page
        end
    end

    // data port write
    always_ff @(posedge clk) begin
        if (port.sel && port.wen) begin
            mem[port.index] <= port.wdata;
        end
    end

    // data port read returns the old word on a same-cycle write
    always_ff @(posedge clk) begin
        if (port.sel && port.ren) begin
            port.rdata <= mem[port.index];
        end
    end

endmodule

`default_nettype wire

/* design/read_mux.sv */
`default_nettype none

module read_mux (
    input  logic        clk,
    input  logic        reset,
    input  logic        ren,
    input  logic        hit,
    input  logic [1:0]  hit_slot,
    slave_if.reader     slv [bus_pkg::SLAVE_COUNT],
    output logic [31:0] rdata,
    output logic        rvalid
);

    logic [31:0] slot_rdata [bus_pkg::SLAVE_COUNT];
    logic [1:0]  slot_q;
    logic        hit_q;

    // return words of all slots as a plain array
    for (genvar k = 0; k < bus_pkg::SLAVE_COUNT; k++) begin : g_flat
        assign slot_rdata[k] = slv[k].rdata;
    end

    // sampled at the same edge the slave registers its word
    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
            hit_q  <= 1'b0;
            slot_q <= '0;
        end else begin
            rvalid <= ren;
            hit_q  <= ren && hit;
            slot_q <= hit_slot;
        end
    end

    assign rdata = hit_q ? slot_rdata[slot_q] : 32'd0;  // unmapped reads return zero

endmodule

`default_nettype wire

/* design/slave_if.sv */
`default_nettype none

// one decoded data access from decoder to slave and the read word back
interface slave_if;

    logic                        sel;    // address falls in this slave
    logic                        ren;    // read strobe already gated by sel
    logic                        wen;    // write strobe already gated by sel
    logic [bus_pkg::INDEX_W-1:0] index;  // word index inside the slave
    logic [31:0]                 wdata;
    logic [31:0]                 rdata;  // registered one cycle after ren

    modport decoder (
        output sel,
        output ren,
        output wen,
        output index,
        output wdata
    );

    modport slave (
        input  sel,
        input  ren,
        input  wen,
        input  index,
        input  wdata,
        output rdata
    );

    modport reader (input rdata);  // return path only

endinterface

`default_nettype wire

/* design/tick_counter.sv */
`default_nettype none

module tick_counter #(
    parameter int PRESCALE = 1
) (
    input  logic   clk,
    input  logic   reset,
    slave_if.slave port
);

    localparam int PRE_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

    logic [PRE_W-1:0] prescale_cnt;
    logic [31:0]      count;
    logic             wrap;

    assign wrap = (prescale_cnt == PRE_W'(PRESCALE - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            prescale_cnt <= '0;
            count        <= '0;
        end else if (port.sel && port.wen) begin
            // software load restarts the prescale period
            count        <= port.wdata;
            prescale_cnt <= '0;
        end else if (wrap) begin
            prescale_cnt <= '0;
            count        <= count + 32'd1;
        end else begin
            prescale_cnt <= prescale_cnt + 1'b1;
        end
    end

    // read returns the count as seen before this edge
    always_ff @(posedge clk) begin
        if (port.sel && port.ren) begin
            port.rdata <= count;
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
design/bus_pkg.sv
design/slave_if.sv
design/bus_decoder.sv
design/program_mem.sv
design/tick_counter.sv
design/read_mux.sv
design/bus_top.sv
testbench/bus_asserts.sv
testbench/bus_tb.sv

/* testbench/bus_asserts.sv */
`default_nettype none

module bus_asserts (
    input logic                            clk,
    input logic                            reset,
    input logic                            ren,
    input logic                            wen,
    input logic                            rvalid,
    input logic [bus_pkg::SLAVE_COUNT-1:0] sel
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // failures seen so far

    strobe_exclusive: assert property (@(posedge clk) disable iff (reset) !(ren && wen))
        else begin
            $error("ren and wen high in the same cycle");
            fail_count++;
        end

    // rvalid is exactly ren delayed by one cycle
    rvalid_after_read: assert property (@(posedge clk) disable iff (reset) ren |=> rvalid)
        else begin
            $error("rvalid missing one cycle after ren");
            fail_count++;
        end

    rvalid_only_after_read: assert property (@(posedge clk) disable iff (reset) !ren |=> !rvalid)
        else begin
            $error("rvalid high without a read in the previous cycle");
            fail_count++;
        end

    single_select: assert property (@(posedge clk) disable iff (reset) $onehot0(sel))
        else begin
            $error("more than one slave selected");
            fail_count++;
        end

endmodule

bind bus_top bus_asserts bus_asserts_i (
    .clk    (clk),
    .reset  (reset),
    .ren    (ren),
    .wen    (wen),
    .rvalid (rvalid),
    .sel    (bus_decoder_i.slot_sel)
);

`default_nettype wire

/* testbench/bus_patterns.txt */
# op address data expected, all hex, expected "computed" comes from the testbench model
# idle keeps the bus quiet for data cycles, fetch drives pc
idle  00000000 00000002 00000000
write 00001000 a5a50001 00000000
write 00001004 0badf00d 00000000
write 00001200 deadbeef 00000000
write 00001ffc 12345678 00000000
read  00001000 00000000 a5a50001
read  00001ffc 00000000 12345678
read  00001200 00000000 deadbeef
read  00001004 00000000 0badf00d
fetch 00001004 00000000 0badf00d
fetch 00001ffc 00000000 12345678
fetch 00003004 00000000 00000000
fetch 00001200 00000000 deadbeef
write 00002000 00000100 00000000
write 00002004 00001000 00000000
read  00002000 00000000 computed
read  00002004 00000000 computed
idle  00000000 0000001e 00000000
read  00002000 00000000 computed
read  00002004 00000000 computed
idle  00000000 00000038 00000000
read  00002004 00000000 computed
read  00003000 00000000 00000000
read  00000000 00000000 00000000
read  00002008 00000000 00000000
write 00003004 ffffffff 00000000
write 00005004 ffffffff 00000000
write 0000200c ffffffff 00000000
read  00001004 00000000 0badf00d
read  00001000 00000000 computed
read  00002004 00000000 computed
read  00001200 00000000 computed
read  00002000 00000000 computed
read  00001ffc 00000000 computed
idle  00000000 00000002 00000000

/* testbench/bus_tb.sv */
`default_nettype none

module bus_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_PATTERNS = 64;

    logic        clk;
    logic        reset;
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] data_addr;
    logic        ren;
    logic        wen;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        rvalid;

    logic [8*10-1:0] pat_op [MAX_PATTERNS];
    logic [31:0]     pat_addr [MAX_PATTERNS];
    logic [31:0]     pat_data [MAX_PATTERNS];
    logic [31:0]     pat_exp [MAX_PATTERNS];
    logic            pat_model [MAX_PATTERNS];  // expected value taken from the model
    int              pat_count = 0;

    logic [31:0] mem_model [bus_pkg::PROG_WORDS];
    logic [31:0] load_val [bus_pkg::TICK_COUNT];
    int          load_edge [bus_pkg::TICK_COUNT];  // edge that sampled the last load

    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 1000;
    int          edge_num = 0;
    int          pend_kind = 0;  // 0 no read, 1 data read, 2 fetch
    logic [31:0] pend_exp = '0;

    bus_top bus_top_i (
        .clk       (clk),
        .reset     (reset),
        .pc        (pc),
        .instr     (instr),
        .data_addr (data_addr),
        .ren       (ren),
        .wen       (wen),
        .wdata     (wdata),
        .rdata     (rdata),
        .rvalid    (rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run still busy after %0d cycles, errors %0d", cycles, errors);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic load_patterns;
        int               fd;
        int               got;
        int               fields;
        logic [8*100-1:0] line;
        logic [8*10-1:0]  op;
        logic [8*10-1:0]  exp_s;
        logic [31:0]      addr;
        logic [31:0]      data;
        fd = $fopen("testbench/bus_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file testbench/bus_patterns.txt");
            errors++;
        end else begin
            while (!$feof(fd) && pat_count < MAX_PATTERNS) begin
                line = '0;
                op = '0;
                exp_s = '0;
                got = $fgets(line, fd);
                fields = $sscanf(line, "%s %h %h %s", op, addr, data, exp_s);
                if (got > 0 && fields == 4) begin  // comment lines stop early
                    pat_op[pat_count]    = op;
                    pat_addr[pat_count]  = addr;
                    pat_data[pat_count]  = data;
                    pat_model[pat_count] = (exp_s == "computed");
                    pat_exp[pat_count]   = '0;
                    if (exp_s != "computed") begin
                        got = $sscanf(exp_s, "%h", pat_exp[pat_count]);
                    end
                    pat_count++;
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic logic [31:0] expected_read(logic [31:0] addr, int sample_edge);
        bus_pkg::bus_addr_u a;
        int                 gap;
        a.raw = addr;
        if (a.fields.page == bus_pkg::PROG_PAGE) begin
            return mem_model[a.fields.word];
        end
        if (a.fields.page == bus_pkg::COUNTER_PAGE && a.fields.word < bus_pkg::TICK_COUNT) begin
            gap = sample_edge - load_edge[a.fields.word];  // counter rule
            return load_val[a.fields.word] + (gap - 1) / bus_pkg::TICK_PRESCALE[a.fields.word];
        end
        return 32'd0;  // unmapped
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                               input int sample_edge);
        bus_pkg::bus_addr_u a;
        a.raw = addr;
        if (a.fields.page == bus_pkg::PROG_PAGE) begin
            mem_model[a.fields.word] = data;
        end else if (a.fields.page == bus_pkg::COUNTER_PAGE &&
                     a.fields.word < bus_pkg::TICK_COUNT) begin
            load_val[a.fields.word]  = data;
            load_edge[a.fields.word] = sample_edge;
        end
    endtask

    task automatic drive_line(input int i, output int kind, output logic [31:0] exp);
        kind = 0;
        exp  = '0;
        ren <= 1'b0;
        wen <= 1'b0;
        if (i < 0) begin
            kind = 0;  // trailing idle cycle
        end else if (pat_op[i] == "write") begin
            data_addr <= pat_addr[i];
            wdata     <= pat_data[i];
            wen       <= 1'b1;
            model_write(pat_addr[i], pat_data[i], edge_num + 1);
        end else if (pat_op[i] == "read") begin
            data_addr <= pat_addr[i];
            ren       <= 1'b1;
            kind = 1;
            exp  = pat_model[i] ? expected_read(pat_addr[i], edge_num + 1) : pat_exp[i];
        end else if (pat_op[i] == "fetch") begin
            pc <= pat_addr[i];
            kind = 2;
            exp  = pat_exp[i];
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED t=%0t %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // drive one cycle, then check what the previous cycle asked for
    task automatic run_cycle(input int i);
        int          kind;
        logic [31:0] exp;
        @(posedge clk);
        edge_num++;
        drive_line(i, kind, exp);
        @(negedge clk);
        compare_word("rvalid", {31'd0, pend_kind == 1}, {31'd0, rvalid});
        if (pend_kind == 1) begin
            compare_word("rdata", pend_exp, rdata);
        end else if (pend_kind == 2) begin
            compare_word("instr", pend_exp, instr);
        end
        pend_kind = kind;
        pend_exp  = exp;
    endtask

    initial begin
        int reps;
        reset     = 1'b1;
        pc        = '0;
        data_addr = '0;
        ren       = 1'b0;
        wen       = 1'b0;
        wdata     = '0;
        load_patterns();
        if (pat_count == 0) begin
            $display("no patterns were read");
            errors++;
        end
        cycle_limit = pat_count * 4 + 100;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compare_word("rvalid", 32'd0, {31'd0, rvalid});
        compare_word("instr", 32'd0, instr);
        for (int i = 0; i < pat_count; i++) begin
            reps = (pat_op[i] == "idle" && pat_data[i] > 1) ? int'(pat_data[i]) : 1;
            repeat (reps) run_cycle(i);
        end
        run_cycle(-1);
        $display("patterns %0d, errors %0d, assertion failures %0d",
                 pat_count, errors, bus_top_i.bus_asserts_i.fail_count);
        if (errors == 0 && bus_top_i.bus_asserts_i.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
